// File: rtl/bypass_macros.svh
`ifndef BYPASS_MACROS_SVH
`define BYPASS_MACROS_SVH

`define BYPASS_DATA_W        64
`define BYPASS_KEEP_W        8   // one enable per data byte

`define BYPASS_FIFO_DEPTH    32  // beats, power of two

// a whole packet must fit the FIFO or store-and-forward stalls forever
`define BYPASS_MAX_PKT_BEATS 16

`endif

// File: rtl/bypass_pkg.sv
`include "bypass_macros.svh"

package bypass_pkg;

    typedef logic [`BYPASS_DATA_W-1:0] data_t;
    typedef logic [`BYPASS_KEEP_W-1:0] keep_t;
    typedef logic [0:0]                port_t;  // source port, carried as tid
    typedef logic [1:0]                dest_t;
    typedef logic [15:0]               cnt_t;   // wraps

    // address plus wrap bit
    typedef logic [$clog2(`BYPASS_FIFO_DEPTH):0] fifo_ptr_t;

    localparam dest_t DEST_PORT0 = 2'd0;
    localparam dest_t DEST_PORT1 = 2'd1;
    localparam dest_t DEST_HOST  = 2'd2;
    localparam dest_t DEST_DROP  = 2'd3;

    typedef enum logic {
        ARB_IDLE,
        ARB_LOCKED
    } arb_state_t;

    typedef enum logic {
        FIFO_IDLE,
        FIFO_STREAM
    } fifo_state_t;

endpackage

// File: rtl/pkt_drop_filter.sv
`timescale 1ns/1ps

module pkt_drop_filter (
    input  logic              core_clk,
    input  logic              core_rstn,

    input  logic              in_valid,
    output logic              in_ready,
    input  bypass_pkg::data_t in_data,
    input  bypass_pkg::keep_t in_keep,
    input  logic              in_last,
    input  bypass_pkg::port_t in_tid,
    input  bypass_pkg::dest_t in_tdest,

    output logic              out_valid,
    input  logic              out_ready,
    output bypass_pkg::data_t out_data,
    output bypass_pkg::keep_t out_keep,
    output logic              out_last,
    output bypass_pkg::port_t out_tid,

    output bypass_pkg::cnt_t  drop_count
);
    import bypass_pkg::*;

    logic sop_q;       // next accepted beat starts a packet
    logic dropping_q;  // inside a packet being discarded
    logic discard;
    logic accept;

    // the code is only meaningful on the first beat
    assign discard = sop_q ? (in_tdest == DEST_DROP) : dropping_q;
    assign accept  = in_valid && in_ready;

    assign in_ready  = discard ? 1'b1 : out_ready;  // swallow dropped beats at full rate
    assign out_valid = in_valid && !discard;
    assign out_data  = in_data;
    assign out_keep  = in_keep;
    assign out_last  = in_last;
    assign out_tid   = in_tid;

    always_ff @(posedge core_clk) begin
        if (!core_rstn) begin
            sop_q      <= 1'b1;
            dropping_q <= 1'b0;
            drop_count <= '0;
        end else if (accept) begin
            sop_q <= in_last;
            if (sop_q) begin
                dropping_q <= discard && !in_last;
                if (discard)
                    drop_count <= drop_count + 1'b1;  // one count per packet
            end else if (in_last) begin
                dropping_q <= 1'b0;
            end
        end
    end

endmodule

// File: rtl/pkt_fifo.sv
`timescale 1ns/1ps
`include "bypass_macros.svh"

module pkt_fifo (
    input  logic              core_clk,
    input  logic              core_rstn,

    input  logic              in_valid,
    output logic              in_ready,
    input  bypass_pkg::data_t in_data,
    input  bypass_pkg::keep_t in_keep,
    input  logic              in_last,
    input  bypass_pkg::port_t in_tid,

    output logic              out_valid,
    input  logic              out_ready,
    output bypass_pkg::data_t out_data,
    output bypass_pkg::keep_t out_keep,
    output logic              out_last,
    output bypass_pkg::port_t out_tid
);
    import bypass_pkg::*;

    localparam int ADDR_W = $clog2(`BYPASS_FIFO_DEPTH);

    data_t mem_data [`BYPASS_FIFO_DEPTH];
    keep_t mem_keep [`BYPASS_FIFO_DEPTH];
    logic  mem_last [`BYPASS_FIFO_DEPTH];
    port_t mem_tid  [`BYPASS_FIFO_DEPTH];

    fifo_ptr_t   wr_ptr;
    fifo_ptr_t   rd_ptr;
    fifo_ptr_t   pkt_cnt;  // complete packets held in memory
    fifo_state_t state;

    logic [ADDR_W-1:0] wr_addr;
    logic [ADDR_W-1:0] rd_addr;
    logic              full;
    logic              wr_en;
    logic              rd_avail;
    logic              rd_en;
    logic              rd_last;

    assign wr_addr = wr_ptr[ADDR_W-1:0];
    assign rd_addr = rd_ptr[ADDR_W-1:0];

    assign full = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                  (wr_addr == rd_addr);

    assign in_ready = !full;
    assign wr_en    = in_valid && in_ready;
    assign rd_last  = mem_last[rd_addr];

    // start only on a fully stored packet, then stream the rest of it
    assign rd_avail = (state == FIFO_STREAM) || (pkt_cnt != '0);
    assign rd_en    = rd_avail && (!out_valid || out_ready);

    always_ff @(posedge core_clk) begin
        if (wr_en) begin
            mem_data[wr_addr] <= in_data;
            mem_keep[wr_addr] <= in_keep;
            mem_last[wr_addr] <= in_last;
            mem_tid[wr_addr]  <= in_tid;
        end
    end

    always_ff @(posedge core_clk) begin  // output stage payload
        if (rd_en) begin
            out_data <= mem_data[rd_addr];
            out_keep <= mem_keep[rd_addr];
            out_last <= rd_last;
            out_tid  <= mem_tid[rd_addr];
        end
    end

    always_ff @(posedge core_clk) begin
        if (!core_rstn) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            pkt_cnt   <= '0;
            state     <= FIFO_IDLE;
            out_valid <= 1'b0;
        end else begin
            if (wr_en)
                wr_ptr <= wr_ptr + 1'b1;
            if (rd_en)
                rd_ptr <= rd_ptr + 1'b1;

            pkt_cnt <= pkt_cnt + fifo_ptr_t'(wr_en && in_last)
                               - fifo_ptr_t'(rd_en && rd_last);

            if (rd_en)
                out_valid <= 1'b1;
            else if (out_ready)
                out_valid <= 1'b0;

            case (state)
                FIFO_IDLE:   if (rd_en && !rd_last) state <= FIFO_STREAM;
                FIFO_STREAM: if (rd_en && rd_last) state <= FIFO_IDLE;
                default:     state <= FIFO_IDLE;
            endcase
        end
    end

endmodule

// File: rtl/path_steer.sv
`timescale 1ns/1ps

module path_steer (
    input  logic              core_clk,
    input  logic              core_rstn,
    input  logic              swap_paths,

    input  logic              in_valid,
    output logic              in_ready,
    input  bypass_pkg::data_t in_data,
    input  bypass_pkg::keep_t in_keep,
    input  logic              in_last,
    input  bypass_pkg::port_t in_tid,

    output logic              a_valid,  // pass
    input  logic              a_ready,
    output bypass_pkg::data_t a_data,
    output bypass_pkg::keep_t a_keep,
    output logic              a_last,
    output bypass_pkg::port_t a_tid,

    output logic              b_valid,  // swap
    input  logic              b_ready,
    output bypass_pkg::data_t b_data,
    output bypass_pkg::keep_t b_keep,
    output logic              b_last,
    output bypass_pkg::port_t b_tid
);
    import bypass_pkg::*;

    logic sop_q;
    logic route_q;  // held from first beat through last
    logic route;

    assign route = sop_q ? swap_paths : route_q;

    assign a_valid = in_valid && !route;
    assign b_valid = in_valid && route;
    assign in_ready = route ? b_ready : a_ready;

    assign a_data = in_data;
    assign a_keep = in_keep;
    assign a_last = in_last;
    assign a_tid  = in_tid;
    assign b_data = in_data;
    assign b_keep = in_keep;
    assign b_last = in_last;
    assign b_tid  = in_tid;

    always_ff @(posedge core_clk) begin
        if (!core_rstn) begin
            sop_q   <= 1'b1;
            route_q <= 1'b0;
        end else if (in_valid && in_ready) begin
            sop_q <= in_last;
            if (sop_q)
                route_q <= swap_paths;
        end
    end

endmodule

// File: rtl/pkt_arbiter.sv
`timescale 1ns/1ps

module pkt_arbiter (
    input  logic              core_clk,
    input  logic              core_rstn,

    input  logic              s0_valid,
    output logic              s0_ready,
    input  bypass_pkg::data_t s0_data,
    input  bypass_pkg::keep_t s0_keep,
    input  logic              s0_last,
    input  bypass_pkg::port_t s0_tid,

    input  logic              s1_valid,
    output logic              s1_ready,
    input  bypass_pkg::data_t s1_data,
    input  bypass_pkg::keep_t s1_keep,
    input  logic              s1_last,
    input  bypass_pkg::port_t s1_tid,

    output logic              out_valid,
    input  logic              out_ready,
    output bypass_pkg::data_t out_data,
    output bypass_pkg::keep_t out_keep,
    output logic              out_last,
    output bypass_pkg::port_t out_tid
);
    import bypass_pkg::*;

    arb_state_t state;
    logic       grant_q;   // source owning the output while locked
    logic       served_q;  // source that finished the previous packet
    logic       pick;
    logic       sel;

    // round robin on contention, otherwise whoever is valid
    assign pick = (s0_valid && s1_valid) ? !served_q : s1_valid;
    assign sel  = (state == ARB_LOCKED) ? grant_q : pick;

    assign out_valid = sel ? s1_valid : s0_valid;
    assign out_data  = sel ? s1_data  : s0_data;
    assign out_keep  = sel ? s1_keep  : s0_keep;
    assign out_last  = sel ? s1_last  : s0_last;
    assign out_tid   = sel ? s1_tid   : s0_tid;

    assign s0_ready = out_ready && !sel;
    assign s1_ready = out_ready && sel;

    always_ff @(posedge core_clk) begin
        if (!core_rstn) begin
            state    <= ARB_IDLE;
            grant_q  <= 1'b0;
            served_q <= 1'b1;  // so input 0 wins first
        end else begin
            case (state)
                ARB_IDLE: begin
                    // lock as soon as a beat is shown so a stalled beat stays put
                    if (out_valid) begin
                        grant_q <= sel;
                        if (out_ready && out_last)
                            served_q <= sel;
                        else
                            state <= ARB_LOCKED;
                    end
                end
                ARB_LOCKED: begin
                    if (out_valid && out_ready && out_last) begin
                        state    <= ARB_IDLE;
                        served_q <= grant_q;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

endmodule

// File: rtl/bypass_top.sv
`timescale 1ns/1ps

module bypass_top (
    input  logic              core_clk,
    input  logic              core_rstn,

    input  logic              in_0_valid,
    output logic              in_0_ready,
    input  bypass_pkg::data_t in_0_data,
    input  bypass_pkg::keep_t in_0_keep,
    input  logic              in_0_last,
    input  bypass_pkg::port_t in_0_tid,
    input  bypass_pkg::dest_t in_0_tdest,

    input  logic              in_1_valid,
    output logic              in_1_ready,
    input  bypass_pkg::data_t in_1_data,
    input  bypass_pkg::keep_t in_1_keep,
    input  logic              in_1_last,
    input  bypass_pkg::port_t in_1_tid,
    input  bypass_pkg::dest_t in_1_tdest,

    input  logic              swap_paths,

    output logic              out_0_valid,
    input  logic              out_0_ready,
    output bypass_pkg::data_t out_0_data,
    output bypass_pkg::keep_t out_0_keep,
    output logic              out_0_last,
    output bypass_pkg::port_t out_0_tid,

    output logic              out_1_valid,
    input  logic              out_1_ready,
    output bypass_pkg::data_t out_1_data,
    output bypass_pkg::keep_t out_1_keep,
    output logic              out_1_last,
    output bypass_pkg::port_t out_1_tid,

    output bypass_pkg::cnt_t  drop_count_0,
    output bypass_pkg::cnt_t  drop_count_1
);
    import bypass_pkg::*;

    // f = filter out, q = fifo out, a/b = steer pass/swap, per lane
    logic  f0_valid, f0_ready, f0_last, f1_valid, f1_ready, f1_last;
    data_t f0_data, f1_data;
    keep_t f0_keep, f1_keep;
    port_t f0_tid, f1_tid;

    logic  q0_valid, q0_ready, q0_last, q1_valid, q1_ready, q1_last;
    data_t q0_data, q1_data;
    keep_t q0_keep, q1_keep;
    port_t q0_tid, q1_tid;

    logic  a0_valid, a0_ready, a0_last, a1_valid, a1_ready, a1_last;
    data_t a0_data, a1_data;
    keep_t a0_keep, a1_keep;
    port_t a0_tid, a1_tid;

    logic  b0_valid, b0_ready, b0_last, b1_valid, b1_ready, b1_last;
    data_t b0_data, b1_data;
    keep_t b0_keep, b1_keep;
    port_t b0_tid, b1_tid;

    pkt_drop_filter filter_0 (
        .core_clk(core_clk), .core_rstn(core_rstn),
        .in_valid(in_0_valid), .in_ready(in_0_ready), .in_data(in_0_data),
        .in_keep(in_0_keep), .in_last(in_0_last), .in_tid(in_0_tid), .in_tdest(in_0_tdest),
        .out_valid(f0_valid), .out_ready(f0_ready), .out_data(f0_data),
        .out_keep(f0_keep), .out_last(f0_last), .out_tid(f0_tid),
        .drop_count(drop_count_0)
    );

    pkt_drop_filter filter_1 (
        .core_clk(core_clk), .core_rstn(core_rstn),
        .in_valid(in_1_valid), .in_ready(in_1_ready), .in_data(in_1_data),
        .in_keep(in_1_keep), .in_last(in_1_last), .in_tid(in_1_tid), .in_tdest(in_1_tdest),
        .out_valid(f1_valid), .out_ready(f1_ready), .out_data(f1_data),
        .out_keep(f1_keep), .out_last(f1_last), .out_tid(f1_tid),
        .drop_count(drop_count_1)
    );

    pkt_fifo fifo_0 (
        .core_clk(core_clk), .core_rstn(core_rstn),
        .in_valid(f0_valid), .in_ready(f0_ready), .in_data(f0_data),
        .in_keep(f0_keep), .in_last(f0_last), .in_tid(f0_tid),
        .out_valid(q0_valid), .out_ready(q0_ready), .out_data(q0_data),
        .out_keep(q0_keep), .out_last(q0_last), .out_tid(q0_tid)
    );

    pkt_fifo fifo_1 (
        .core_clk(core_clk), .core_rstn(core_rstn),
        .in_valid(f1_valid), .in_ready(f1_ready), .in_data(f1_data),
        .in_keep(f1_keep), .in_last(f1_last), .in_tid(f1_tid),
        .out_valid(q1_valid), .out_ready(q1_ready), .out_data(q1_data),
        .out_keep(q1_keep), .out_last(q1_last), .out_tid(q1_tid)
    );

    path_steer steer_0 (
        .core_clk(core_clk), .core_rstn(core_rstn), .swap_paths(swap_paths),
        .in_valid(q0_valid), .in_ready(q0_ready), .in_data(q0_data),
        .in_keep(q0_keep), .in_last(q0_last), .in_tid(q0_tid),
        .a_valid(a0_valid), .a_ready(a0_ready), .a_data(a0_data),
        .a_keep(a0_keep), .a_last(a0_last), .a_tid(a0_tid),
        .b_valid(b0_valid), .b_ready(b0_ready), .b_data(b0_data),
        .b_keep(b0_keep), .b_last(b0_last), .b_tid(b0_tid)
    );

    path_steer steer_1 (
        .core_clk(core_clk), .core_rstn(core_rstn), .swap_paths(swap_paths),
        .in_valid(q1_valid), .in_ready(q1_ready), .in_data(q1_data),
        .in_keep(q1_keep), .in_last(q1_last), .in_tid(q1_tid),
        .a_valid(a1_valid), .a_ready(a1_ready), .a_data(a1_data),
        .a_keep(a1_keep), .a_last(a1_last), .a_tid(a1_tid),
        .b_valid(b1_valid), .b_ready(b1_ready), .b_data(b1_data),
        .b_keep(b1_keep), .b_last(b1_last), .b_tid(b1_tid)
    );

    // own lane on input 0, the crossed lane on input 1
    pkt_arbiter arb_0 (
        .core_clk(core_clk), .core_rstn(core_rstn),
        .s0_valid(a0_valid), .s0_ready(a0_ready), .s0_data(a0_data),
        .s0_keep(a0_keep), .s0_last(a0_last), .s0_tid(a0_tid),
        .s1_valid(b1_valid), .s1_ready(b1_ready), .s1_data(b1_data),
        .s1_keep(b1_keep), .s1_last(b1_last), .s1_tid(b1_tid),
        .out_valid(out_0_valid), .out_ready(out_0_ready), .out_data(out_0_data),
        .out_keep(out_0_keep), .out_last(out_0_last), .out_tid(out_0_tid)
    );

    pkt_arbiter arb_1 (
        .core_clk(core_clk), .core_rstn(core_rstn),
        .s0_valid(a1_valid), .s0_ready(a1_ready), .s0_data(a1_data),
        .s0_keep(a1_keep), .s0_last(a1_last), .s0_tid(a1_tid),
        .s1_valid(b0_valid), .s1_ready(b0_ready), .s1_data(b0_data),
        .s1_keep(b0_keep), .s1_last(b0_last), .s1_tid(b0_tid),
        .out_valid(out_1_valid), .out_ready(out_1_ready), .out_data(out_1_data),
        .out_keep(out_1_keep), .out_last(out_1_last), .out_tid(out_1_tid)
    );

endmodule

// File: tests/bypass_checker.sv
`timescale 1ns/1ps

module bypass_checker (
    input logic              core_clk,
    input logic              core_rstn,
    input logic              swap_paths,
    input logic              in_0_valid, in_0_ready, in_0_last,
    input bypass_pkg::data_t in_0_data,
    input bypass_pkg::keep_t in_0_keep,
    input bypass_pkg::dest_t in_0_tdest,
    input logic              in_1_valid, in_1_ready, in_1_last,
    input bypass_pkg::data_t in_1_data,
    input bypass_pkg::keep_t in_1_keep,
    input bypass_pkg::dest_t in_1_tdest,
    input logic              out_0_valid, out_0_ready, out_0_last,
    input bypass_pkg::data_t out_0_data,
    input bypass_pkg::keep_t out_0_keep,
    input bypass_pkg::port_t out_0_tid,
    input logic              out_1_valid, out_1_ready, out_1_last,
    input bypass_pkg::data_t out_1_data,
    input bypass_pkg::keep_t out_1_keep,
    input bypass_pkg::port_t out_1_tid,
    input bypass_pkg::cnt_t  drop_count_0,
    input bypass_pkg::cnt_t  drop_count_1
);
    import bypass_pkg::*;

    logic [72:0] exp_q [4][$];  // {last, keep, data}, index output*2 + source
    logic        in_sop [2];
    logic        in_drop [2];
    logic        in_route [2];
    logic        out_busy [2];    // output is inside a packet
    logic        out_src [2];
    cnt_t        drop_model [2];
    logic        rst_seen = 1'b0;
    int          settle = 0;
    int          errors = 0;

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("FAILED %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic check_reset_state();
        if (out_0_valid !== 1'b0 || out_1_valid !== 1'b0) begin
            errors++;
            $display("an output valid is not low during or just after reset");
        end
        check_value("drop_count_0", 64'h0, 64'(drop_count_0));
        check_value("drop_count_1", 64'h0, 64'(drop_count_1));
    endtask

    task automatic watch_input(input int p, input logic valid, input logic ready,
                               input data_t data, input keep_t keep, input logic last,
                               input dest_t tdest);
        int idx;
        if (valid && ready) begin
            if (in_sop[p]) begin
                in_drop[p]  = (tdest == DEST_DROP);
                in_route[p] = swap_paths;  // crossed output when high
                if (in_drop[p])
                    drop_model[p] = drop_model[p] + 1'b1;
            end
            idx = (p ^ int'(in_route[p])) * 2 + p;
            if (!in_drop[p])
                exp_q[idx].push_back({last, keep, data});
            in_sop[p] = last;
        end
    endtask

    task automatic watch_output(input int k, input logic valid, input logic ready,
                                input data_t data, input keep_t keep, input logic last,
                                input port_t tid);
        int          idx;
        logic [72:0] beat;
        if (valid && ready) begin
            if (out_busy[k])
                check_value($sformatf("out_%0d_tid", k), 64'(out_src[k]), 64'(tid));
            idx = k * 2 + int'(tid);
            if (exp_q[idx].size() == 0) begin
                errors++;
                $display("unexpected beat on out_%0d from source %0d", k, tid);
            end else begin
                beat = exp_q[idx].pop_front();
                check_value($sformatf("out_%0d_data", k), beat[63:0], data);
                check_value($sformatf("out_%0d_keep", k), 64'(beat[71:64]), 64'(keep));
                check_value($sformatf("out_%0d_last", k), 64'(beat[72]), 64'(last));
            end
            out_busy[k] = !last;
            out_src[k]  = tid;
        end
    endtask

    always @(posedge core_clk) begin
        if (!core_rstn) begin
            if (rst_seen)
                check_reset_state();  // values before the first edge are unknown
            rst_seen = 1'b1;
            settle   = 0;
            for (int p = 0; p < 2; p++) begin
                in_sop[p]     = 1'b1;
                in_drop[p]    = 1'b0;
                in_route[p]   = 1'b0;
                out_busy[p]   = 1'b0;
                out_src[p]    = 1'b0;
                drop_model[p] = '0;
            end
        end else begin
            if (settle < 2) begin
                check_reset_state();
                settle++;
            end
            check_value("drop_count_0", 64'(drop_model[0]), 64'(drop_count_0));
            check_value("drop_count_1", 64'(drop_model[1]), 64'(drop_count_1));
            watch_input(0, in_0_valid, in_0_ready, in_0_data, in_0_keep, in_0_last,
                        in_0_tdest);
            watch_input(1, in_1_valid, in_1_ready, in_1_data, in_1_keep, in_1_last,
                        in_1_tdest);
            watch_output(0, out_0_valid, out_0_ready, out_0_data, out_0_keep, out_0_last,
                         out_0_tid);
            watch_output(1, out_1_valid, out_1_ready, out_1_data, out_1_keep, out_1_last,
                         out_1_tid);
        end
    end

    // totals from the stimulus table, checked once traffic has drained
    task automatic final_check(input cnt_t exp0, input cnt_t exp1);
        check_value("drop_count_0", 64'(exp0), 64'(drop_count_0));
        check_value("drop_count_1", 64'(exp1), 64'(drop_count_1));
        for (int i = 0; i < 4; i++) begin
            if (exp_q[i].size() != 0) begin
                errors++;
                $display("%0d beats from source %0d never arrived on out_%0d",
                         exp_q[i].size(), i % 2, i / 2);
            end
        end
    endtask

endmodule

// File: tests/tb_bypass.sv
`timescale 1ns/1ps

module tb_bypass;
    import bypass_pkg::*;

    typedef struct packed {
        logic       barrier;  // drain, then apply swap and rate
        logic [1:0] rate;     // 0 full rate, 1 random, 2 long stalls
        logic       swap;
        logic       port;
        logic [4:0] beats;
        dest_t      dest;
        data_t      word;
    } row_t;

    logic  core_clk    = 1'b0;
    logic  core_rstn   = 1'b0;
    logic  swap_paths  = 1'b0;
    logic  in_0_valid  = 1'b0;
    logic  in_0_last   = 1'b0;
    data_t in_0_data   = '0;
    keep_t in_0_keep   = '0;
    port_t in_0_tid    = '0;
    dest_t in_0_tdest  = '0;
    logic  in_1_valid  = 1'b0;
    logic  in_1_last   = 1'b0;
    data_t in_1_data   = '0;
    keep_t in_1_keep   = '0;
    port_t in_1_tid    = '0;
    dest_t in_1_tdest  = '0;
    logic  out_0_ready = 1'b0;
    logic  out_1_ready = 1'b0;

    logic  in_0_ready, in_1_ready;
    logic  out_0_valid, out_0_last, out_1_valid, out_1_last;
    data_t out_0_data, out_1_data;
    keep_t out_0_keep, out_1_keep;
    port_t out_0_tid, out_1_tid;
    cnt_t  drop_count_0, drop_count_1;

    row_t       rows [$];
    logic [1:0] rate = 2'd0;
    logic       draining = 1'b0;
    int         stall [2] = '{0, 0};
    cnt_t       exp_drops [2] = '{16'd0, 16'd0};

    bypass_top dut0 (.*);
    bypass_checker chk0 (.*);

    initial begin
        forever #20 core_clk = ~core_clk;
    end

    task automatic add_row(input logic barrier, input logic [1:0] rt, input logic sw,
                           input logic port, input int beats, input dest_t dest,
                           input data_t word);
        row_t r;
        r = '{barrier, rt, sw, port, 5'(beats), dest, word};
        rows.push_back(r);
    endtask

    task automatic load_table();
        add_row(1, 2'd1, 0, 0, 0, DEST_PORT0, 64'h0);  // pass-through, random ready
        add_row(0, 2'd0, 0, 0, 4, DEST_PORT1, 64'h0100_0000_0000_1001);
        add_row(0, 2'd0, 0, 1, 1, DEST_PORT0, 64'h0200_0000_0000_2003);
        add_row(0, 2'd0, 0, 0, 16, DEST_HOST, 64'h0100_0000_0001_0000);
        add_row(0, 2'd0, 0, 1, 3, DEST_DROP, 64'h0200_0000_0002_0005);
        add_row(0, 2'd0, 0, 1, 5, DEST_PORT0, 64'h0200_0000_0003_0002);
        add_row(0, 2'd0, 0, 0, 2, DEST_DROP, 64'h0100_0000_0002_0007);
        add_row(0, 2'd0, 0, 0, 1, DEST_PORT1, 64'h0100_0000_0003_0006);
        add_row(0, 2'd0, 0, 1, 8, DEST_HOST, 64'h0200_0000_0004_0001);
        add_row(1, 2'd0, 1, 0, 0, DEST_PORT0, 64'h0);  // swap at full rate
        add_row(0, 2'd0, 0, 0, 3, DEST_PORT0, 64'h0100_0000_0004_0004);
        add_row(0, 2'd0, 0, 1, 6, DEST_PORT1, 64'h0200_0000_0005_0000);
        add_row(0, 2'd0, 0, 0, 1, DEST_DROP, 64'h0100_0000_0005_0003);
        add_row(0, 2'd0, 0, 1, 16, DEST_HOST, 64'h0200_0000_0006_0006);
        add_row(0, 2'd0, 0, 0, 16, DEST_PORT1, 64'h0100_0000_0006_0005);
        add_row(0, 2'd0, 0, 1, 2, DEST_DROP, 64'h0200_0000_0007_0004);
        add_row(1, 2'd2, 0, 0, 0, DEST_PORT0, 64'h0);  // long stalls fill the FIFOs
        add_row(0, 2'd0, 0, 0, 16, DEST_PORT0, 64'h0100_0000_0007_0001);
        add_row(0, 2'd0, 0, 0, 16, DEST_HOST, 64'h0100_0000_0008_0002);
        add_row(0, 2'd0, 0, 0, 16, DEST_PORT1, 64'h0100_0000_0009_0007);
        add_row(0, 2'd0, 0, 1, 16, DEST_PORT1, 64'h0200_0000_0008_0003);
        add_row(0, 2'd0, 0, 1, 16, DEST_PORT0, 64'h0200_0000_0009_0006);
        add_row(0, 2'd0, 0, 1, 1, DEST_DROP, 64'h0200_0000_000a_0002);
        add_row(0, 2'd0, 0, 1, 12, DEST_HOST, 64'h0200_0000_000b_0005);
        add_row(1, 2'd1, 1, 0, 0, DEST_PORT0, 64'h0);  // swap with random ready
        add_row(0, 2'd0, 0, 0, 7, DEST_PORT0, 64'h0100_0000_000a_0006);
        add_row(0, 2'd0, 0, 1, 4, DEST_PORT1, 64'h0200_0000_000c_0007);
        add_row(0, 2'd0, 0, 0, 16, DEST_DROP, 64'h0100_0000_000b_0001);
        add_row(0, 2'd0, 0, 1, 9, DEST_HOST, 64'h0200_0000_000d_0001);
        add_row(0, 2'd0, 0, 0, 2, DEST_PORT1, 64'h0100_0000_000c_0003);
        add_row(1, 2'd0, 0, 0, 0, DEST_PORT0, 64'h0);  // final drain
    endtask

    task automatic send_packet(input row_t r);
        for (int b = 0; b < int'(r.beats); b++) begin
            if (r.port == 1'b0) begin
                in_0_valid <= 1'b1;
                in_0_data  <= r.word + data_t'(b);
                in_0_keep  <= (b == int'(r.beats) - 1) ? (8'hff >> r.word[2:0]) : 8'hff;
                in_0_last  <= (b == int'(r.beats) - 1);
                in_0_tid   <= 1'b0;
                in_0_tdest <= r.dest;
            end else begin
                in_1_valid <= 1'b1;
                in_1_data  <= r.word + data_t'(b);
                in_1_keep  <= (b == int'(r.beats) - 1) ? (8'hff >> r.word[2:0]) : 8'hff;
                in_1_last  <= (b == int'(r.beats) - 1);
                in_1_tid   <= 1'b1;
                in_1_tdest <= r.dest;
            end
            @(posedge core_clk);
            while (!(r.port ? in_1_ready : in_0_ready))
                @(posedge core_clk);
        end
        if (r.port == 1'b0)
            in_0_valid <= 1'b0;
        else
            in_1_valid <= 1'b0;
        repeat ($urandom_range(0, 2)) @(posedge core_clk);
    endtask

    task automatic drive_port(input logic p, input int first, input int stop);
        for (int i = first; i < stop; i++) begin
            if (!rows[i].barrier && rows[i].port == p)
                send_packet(rows[i]);
        end
    endtask

    task automatic drain();
        int idle;
        idle = 0;
        draining <= 1'b1;
        while (idle < 40) begin
            @(posedge core_clk);
            idle = (out_0_valid || out_1_valid) ? 0 : idle + 1;
        end
        draining <= 1'b0;
    endtask

    function automatic logic next_ready(input int k);
        if (draining || rate == 2'd0)
            return 1'b1;
        if (rate == 2'd1)
            return ($urandom_range(0, 3) != 0);
        if (stall[k] > 0) begin
            stall[k]--;
            return 1'b0;
        end
        if ($urandom_range(0, 15) == 0)
            stall[k] = $urandom_range(20, 60);  // long enough to back up a FIFO
        return 1'b1;
    endfunction

    always @(posedge core_clk) begin
        out_0_ready <= next_ready(0);
        out_1_ready <= next_ready(1);
    end

    task automatic watchdog(input int limit);
        repeat (limit) @(posedge core_clk);
        $display("timeout: run did not finish within %0d cycles", limit);
        $display("SOME TESTS FAILED");
        $finish;
    endtask

    initial begin
        int seg;
        int total_beats;
        void'($urandom(32'h3dd2b315));
        load_table();
        total_beats = 0;
        foreach (rows[i]) begin
            total_beats += int'(rows[i].beats);
            if (!rows[i].barrier && rows[i].dest == DEST_DROP)
                exp_drops[rows[i].port] = exp_drops[rows[i].port] + 1'b1;
        end
        fork
            watchdog(200 * total_beats + 1000);
        join_none
        repeat (3) @(posedge core_clk);
        core_rstn <= 1'b1;
        @(posedge core_clk);
        seg = 0;
        for (int i = 0; i < rows.size(); i++) begin
            if (rows[i].barrier) begin
                fork
                    drive_port(1'b0, seg, i);
                    drive_port(1'b1, seg, i);
                join
                drain();
                swap_paths <= rows[i].swap;
                rate       <= rows[i].rate;
                seg = i + 1;
            end
        end
        chk0.final_check(exp_drops[0], exp_drops[1]);
        $display("errors: %0d", chk0.errors);
        if (chk0.errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// File: list.f
+incdir+rtl
rtl/bypass_pkg.sv
rtl/pkt_drop_filter.sv
rtl/pkt_fifo.sv
rtl/path_steer.sv
rtl/pkt_arbiter.sv
rtl/bypass_top.sv
tests/bypass_checker.sv
tests/tb_bypass.sv

// File: Makefile
# Verilator build and run of the bypass testbench

VERILATOR ?= verilator
TOP       ?= tb_bypass
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; rc=$$?; cat $(LOG); \
	test $$rc -eq 0 && ! grep -q "SOME TESTS FAILED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
